/* verilog/uart_cmd_config.svh */
// command port configuration
`ifndef UART_CMD_CONFIG_SVH
`define UART_CMD_CONFIG_SVH

// clk_sys cycles per serial bit
`define UC_CLKS_PER_BIT 8

// max idle cycles between two bytes of one frame
`define UC_TIMEOUT_CYCLES 400

// device byte this port answers to
`define UC_DEV_ID 8'h5A

// reply byte for an accepted write
`define UC_ACK_BYTE 8'hA5

// register count, also the valid address range
`define UC_REG_NUM 16

`endif

/* verilog/uart_cmd_pkg.sv */
// command port shared types
`default_nettype none

package uart_cmd_pkg;

	// mode byte opcodes, anything else is rejected by the decoder
	typedef enum logic [7:0] {
		CMD_WR = 8'h01,
		CMD_RD = 8'h02
	} cmd_op_e;

	// frame decoder, one state per expected byte
	typedef enum logic [2:0] {
		DEC_IDLE,
		DEC_MOD,
		DEC_ADDR,
		DEC_DATA,
		DEC_DONE,
		DEC_FAIL
	} dec_state_e;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_e;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_e;

endpackage

`default_nettype wire

/* verilog/uart_rx.sv */
// uart byte receiver
`timescale 1ns/1ns
`default_nettype none
`include "uart_cmd_config.svh"

module uart_rx
	import uart_cmd_pkg::*;
(
	input  wire        clk_sys,
	input  wire        rst_n,
	input  wire        rxd,
	output logic [7:0] rx_data,
	output logic       rx_vld
);

	localparam int CW = $clog2(`UC_CLKS_PER_BIT);
	localparam logic [CW-1:0] BIT_LAST = CW'(`UC_CLKS_PER_BIT - 1);
	localparam logic [CW-1:0] HALF_LAST = CW'(`UC_CLKS_PER_BIT / 2 - 1);

	logic rxd_meta;
	logic rxd_sync;
	rx_state_e state;
	logic [CW-1:0] clk_cnt;
	logic [2:0] bit_cnt;
	logic [7:0] shift_reg;
	logic bit_end;
	logic half_end;

	assign bit_end = (clk_cnt == BIT_LAST);
	assign half_end = (clk_cnt == HALF_LAST);

	// two-flop synchronizer, line idles high
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state <= RX_IDLE;
			clk_cnt <= '0;
			bit_cnt <= '0;
			rx_vld <= 1'b0;
		end else begin
			rx_vld <= 1'b0;
			case (state)
				RX_IDLE: begin
					clk_cnt <= '0;
					if (!rxd_sync)
						state <= RX_START;
				end
				RX_START: begin
					// glitch shorter than half a bit goes back to idle
					if (half_end) begin
						clk_cnt <= '0;
						bit_cnt <= '0;
						state <= rxd_sync ? RX_IDLE : RX_DATA;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				RX_DATA: begin
					if (bit_end) begin
						clk_cnt <= '0;
						if (bit_cnt == 3'd7)
							state <= RX_STOP;
						else
							bit_cnt <= bit_cnt + 1'b1;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				RX_STOP: begin
					// framing error drops the byte silently
					if (bit_end) begin
						rx_vld <= rxd_sync;
						state <= RX_IDLE;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// lsb first, sampled mid-bit
	always_ff @(posedge clk_sys) begin
		if (state == RX_DATA && bit_end)
			shift_reg <= {rxd_sync, shift_reg[7:1]};
		if (state == RX_STOP && bit_end && rxd_sync)
			rx_data <= shift_reg;
	end

	rx_vld_single: assert property (@(posedge clk_sys) disable iff (!rst_n)
		rx_vld |=> !rx_vld);

endmodule

`default_nettype wire

/* verilog/cmd_frame_dec.sv */
// command frame decoder
`timescale 1ns/1ns
`default_nettype none
`include "uart_cmd_config.svh"

module cmd_frame_dec
	import uart_cmd_pkg::*;
(
	input  wire        clk_sys,
	input  wire        rst_n,
	input  wire        rx_vld,
	input  wire  [7:0] rx_data,
	output cmd_op_e    cmd_op,
	output logic [7:0] cmd_addr,
	output logic [7:0] cmd_data,
	output logic       cmd_vld
);

	localparam int TW = $clog2(`UC_TIMEOUT_CYCLES + 1);

	dec_state_e state;
	logic [TW-1:0] tmo_cnt;
	logic tmo_hit;
	logic wait_byte;
	logic frame_last;
	logic frame_ok;
	logic dev_match;
	logic op_known;
	logic [7:0] dev_byte;
	logic [7:0] mode_byte;
	logic [7:0] addr_byte;

	assign wait_byte = (state == DEC_MOD) || (state == DEC_ADDR) || (state == DEC_DATA);
	assign tmo_hit = (tmo_cnt == TW'(`UC_TIMEOUT_CYCLES));
	assign frame_last = (state == DEC_DATA) && rx_vld && !tmo_hit;
	assign dev_match = (dev_byte == `UC_DEV_ID);
	assign op_known = (mode_byte == CMD_WR) || (mode_byte == CMD_RD);

	// gap counter, restarts on each byte
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			tmo_cnt <= '0;
		else if (!wait_byte || rx_vld)
			tmo_cnt <= '0;
		else
			tmo_cnt <= tmo_cnt + 1'b1;
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state <= DEC_IDLE;
			frame_ok <= 1'b0;
		end else begin
			case (state)
				DEC_IDLE: state <= rx_vld ? DEC_MOD : DEC_IDLE;
				DEC_MOD:  state <= tmo_hit ? DEC_FAIL : (rx_vld ? DEC_ADDR : DEC_MOD);
				DEC_ADDR: state <= tmo_hit ? DEC_FAIL : (rx_vld ? DEC_DATA : DEC_ADDR);
				DEC_DATA: state <= tmo_hit ? DEC_FAIL : (rx_vld ? DEC_DONE : DEC_DATA);
				DEC_DONE: state <= DEC_IDLE;
				DEC_FAIL: state <= DEC_IDLE;
				default:  state <= DEC_IDLE;
			endcase
			if (frame_last)
				frame_ok <= dev_match && op_known;
		end
	end

	// header bytes staged, outputs only move on a complete frame
	always_ff @(posedge clk_sys) begin
		if (rx_vld) begin
			case (state)
				DEC_IDLE: dev_byte <= rx_data;
				DEC_MOD:  mode_byte <= rx_data;
				DEC_ADDR: addr_byte <= rx_data;
				default: ;
			endcase
		end
		if (frame_last) begin
			cmd_op <= cmd_op_e'(mode_byte);
			cmd_addr <= addr_byte;
			cmd_data <= rx_data;
		end
	end

	assign cmd_vld = (state == DEC_DONE) && frame_ok;

	cmd_vld_after_frame: assert property (@(posedge clk_sys) disable iff (!rst_n)
		cmd_vld |-> ($past(state) == DEC_DATA) && $past(rx_vld));

endmodule

`default_nettype wire

/* verilog/reg_bank.sv */
// command register bank
`timescale 1ns/1ns
`default_nettype none
`include "uart_cmd_config.svh"

module reg_bank
	import uart_cmd_pkg::*;
(
	input  wire        clk_sys,
	input  wire        rst_n,
	input  wire        cmd_vld,
	input  wire cmd_op_e cmd_op,
	input  wire  [7:0] cmd_addr,
	input  wire  [7:0] cmd_data,
	input  wire        tx_busy,
	output logic [7:0] tx_data,
	output logic       tx_start
);

	localparam int AW = $clog2(`UC_REG_NUM);

	logic [7:0] regs [`UC_REG_NUM];
	logic [AW-1:0] idx;
	logic addr_ok;
	logic accept;
	logic pend;

	assign idx = cmd_addr[AW-1:0];
	assign addr_ok = (cmd_addr < 8'(`UC_REG_NUM));
	assign accept = cmd_vld && addr_ok;

	// registers come up zero
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `UC_REG_NUM; i++)
				regs[i] <= 8'h00;
		end else if (accept && cmd_op == CMD_WR) begin
			regs[idx] <= cmd_data;
		end
	end

	// reply byte, read returns the old contents
	always_ff @(posedge clk_sys) begin
		if (accept)
			tx_data <= (cmd_op == CMD_WR) ? `UC_ACK_BYTE : regs[idx];
	end

	// new command wins over the clear from tx_start
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			pend <= 1'b0;
		else if (accept)
			pend <= 1'b1;
		else if (tx_start)
			pend <= 1'b0;
	end

	assign tx_start = pend && !tx_busy;

	// transmitter must pick up every start
	tx_start_taken: assert property (@(posedge clk_sys) disable iff (!rst_n)
		tx_start |-> !tx_busy ##1 tx_busy);

	reply_not_lost: assert property (@(posedge clk_sys) disable iff (!rst_n)
		accept |-> !pend || tx_start);

endmodule

`default_nettype wire

/* verilog/uart_tx.sv */
// uart byte transmitter
`timescale 1ns/1ns
`default_nettype none
`include "uart_cmd_config.svh"

module uart_tx
	import uart_cmd_pkg::*;
(
	input  wire        clk_sys,
	input  wire        rst_n,
	input  wire        tx_start,
	input  wire  [7:0] tx_data,
	output logic       txd,
	output logic       tx_busy
);

	localparam int CW = $clog2(`UC_CLKS_PER_BIT);
	localparam logic [CW-1:0] BIT_LAST = CW'(`UC_CLKS_PER_BIT - 1);

	tx_state_e state;
	logic [CW-1:0] clk_cnt;
	logic [2:0] bit_cnt;
	logic [7:0] shift_reg;
	logic bit_end;
	logic load;

	assign bit_end = (clk_cnt == BIT_LAST);
	assign load = (state == TX_IDLE) && tx_start;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state <= TX_IDLE;
			clk_cnt <= '0;
			bit_cnt <= '0;
			txd <= 1'b1;
		end else begin
			clk_cnt <= (state == TX_IDLE || bit_end) ? '0 : clk_cnt + 1'b1;
			case (state)
				TX_IDLE: begin
					if (tx_start) begin
						txd <= 1'b0;
						state <= TX_START;
					end
				end
				TX_START: begin
					if (bit_end) begin
						txd <= shift_reg[0];
						bit_cnt <= '0;
						state <= TX_DATA;
					end
				end
				TX_DATA: begin
					if (bit_end) begin
						if (bit_cnt == 3'd7) begin
							txd <= 1'b1;
							state <= TX_STOP;
						end else begin
							txd <= shift_reg[0];
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				TX_STOP: begin
					if (bit_end)
						state <= TX_IDLE;
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// next bit always sits in shift_reg[0]
	always_ff @(posedge clk_sys) begin
		if (load)
			shift_reg <= tx_data;
		else if (bit_end && (state == TX_START || state == TX_DATA))
			shift_reg <= {1'b0, shift_reg[7:1]};
	end

	assign tx_busy = (state != TX_IDLE);

endmodule

`default_nettype wire

/* verilog/uart_cmd_top.sv */
// serial command port top
`timescale 1ns/1ns
`default_nettype none

module uart_cmd_top
	import uart_cmd_pkg::*;
(
	input  wire  clk_sys,
	input  wire  rst_n,
	input  wire  rxd,
	output logic txd
);

	logic [7:0] rx_data;
	logic rx_vld;
	cmd_op_e cmd_op;
	logic [7:0] cmd_addr;
	logic [7:0] cmd_data;
	logic cmd_vld;
	logic [7:0] tx_data;
	logic tx_start;
	logic tx_busy;

	// input side
	uart_rx uart_rx_inst (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.rxd     (rxd),
		.rx_data (rx_data),
		.rx_vld  (rx_vld)
	);

	cmd_frame_dec cmd_frame_dec_inst (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.rx_vld   (rx_vld),
		.rx_data  (rx_data),
		.cmd_op   (cmd_op),
		.cmd_addr (cmd_addr),
		.cmd_data (cmd_data),
		.cmd_vld  (cmd_vld)
	);

	reg_bank reg_bank_inst (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.cmd_vld  (cmd_vld),
		.cmd_op   (cmd_op),
		.cmd_addr (cmd_addr),
		.cmd_data (cmd_data),
		.tx_busy  (tx_busy),
		.tx_data  (tx_data),
		.tx_start (tx_start)
	);

	// reply side
	uart_tx uart_tx_inst (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.tx_start (tx_start),
		.tx_data  (tx_data),
		.txd      (txd),
		.tx_busy  (tx_busy)
	);

endmodule

`default_nettype wire

/* testbench/tb_uart_cmd_top.sv */
// uart command port testbench
`timescale 1ns/1ns
`default_nettype none
`include "uart_cmd_config.svh"

module tb_uart_cmd_top
	import uart_cmd_pkg::*;
();

	localparam int CLKS = `UC_CLKS_PER_BIT;
	localparam int DRV_DLY = 5;
	localparam int FRAME_CYC = 40 * CLKS;
	localparam int REPLY_CYC = 10 * CLKS;
	localparam int SILENCE_CYC = 200 * CLKS;
	// reply wait counts from the first byte of the command frame
	localparam int RECV_LIMIT = FRAME_CYC + 2 * REPLY_CYC;
	// 40 replied frames plus 3 silent and one stalled frame with some margin
	localparam int CYCLE_LIMIT = 45 * (FRAME_CYC + REPLY_CYC + 16)
		+ 4 * SILENCE_CYC + 2 * `UC_TIMEOUT_CYCLES + 1000;

	logic clk_sys;
	logic rst_n;
	logic rxd;
	logic txd;
	logic [7:0] model [`UC_REG_NUM];
	integer seed;
	int cycle_cnt = 0;

	uart_cmd_top uart_cmd_top_inst (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.rxd     (rxd),
		.txd     (txd)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	// watchdog
	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT)
			abort_run("run went past its cycle limit before the tests finished");
	end

	// drive point is a few ns after the rising edge
	task automatic align_drive();
		@(posedge clk_sys);
		#DRV_DLY;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_sys);
		#DRV_DLY;
	endtask

	task automatic compare_byte(input string test, input string what,
		input logic [7:0] exp, input logic [7:0] act);
		assert (act === exp)
		else abort_run($sformatf("ERR %s %s expected 0x%02h actual 0x%02h",
			test, what, exp, act));
	endtask

	// 8N1 lsb first from a drive point
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			rxd = bits[i];
			wait_cycles(CLKS);
		end
	endtask

	task automatic send_frame(input logic [7:0] dev, input logic [7:0] mode,
		input logic [7:0] addr, input logic [7:0] data);
		align_drive();
		send_byte(dev);
		send_byte(mode);
		send_byte(addr);
		send_byte(data);
	endtask

	// txd sampled on falling edges away from its update
	task automatic recv_byte(input string test, output logic [7:0] b);
		int waited;
		waited = 0;
		b = 8'h00;
		do begin
			@(negedge clk_sys);
			waited++;
		end while (txd !== 1'b0 && waited < RECV_LIMIT);
		assert (txd === 1'b0)
		else abort_run($sformatf("%s got no reply start bit on txd", test));
		repeat (CLKS / 2) @(negedge clk_sys);
		assert (txd === 1'b0)
		else abort_run($sformatf("%s saw a start bit on txd shorter than half a bit", test));
		for (int i = 0; i < 8; i++) begin
			repeat (CLKS) @(negedge clk_sys);
			b[i] = txd;
		end
		repeat (CLKS) @(negedge clk_sys);
		assert (txd === 1'b1)
		else abort_run($sformatf("%s got a reply with a low stop bit", test));
		// let the stop bit run out
		repeat (CLKS / 2) @(negedge clk_sys);
	endtask

	task automatic expect_silence(input string test);
		repeat (SILENCE_CYC) begin
			@(negedge clk_sys);
			assert (txd === 1'b1)
			else abort_run($sformatf("%s sent a reply where none was expected", test));
		end
	endtask

	task automatic command_reply(input string test, input logic [7:0] dev,
		input logic [7:0] mode, input logic [7:0] addr, input logic [7:0] data,
		output logic [7:0] reply);
		logic [7:0] got;
		fork
			send_frame(dev, mode, addr, data);
			recv_byte(test, got);
		join
		reply = got;
	endtask

	task automatic command_silent(input string test, input logic [7:0] dev,
		input logic [7:0] mode, input logic [7:0] addr, input logic [7:0] data);
		fork
			send_frame(dev, mode, addr, data);
			expect_silence(test);
		join
	endtask

	task automatic write_reg(input string test, input logic [7:0] addr,
		input logic [7:0] data);
		logic [7:0] reply;
		command_reply(test, `UC_DEV_ID, CMD_WR, addr, data, reply);
		compare_byte(test, $sformatf("ack of write to reg %0d", addr), `UC_ACK_BYTE, reply);
		model[addr] = data;
	endtask

	task automatic read_reg(input string test, input logic [7:0] addr);
		logic [7:0] reply;
		command_reply(test, `UC_DEV_ID, CMD_RD, addr, 8'h00, reply);
		compare_byte(test, $sformatf("read of reg %0d", addr), model[addr], reply);
	endtask

	task automatic test_reset_read();
		logic [7:0] reply;
		for (int i = 0; i < `UC_REG_NUM; i += 5) begin
			command_reply("test_reset_read", `UC_DEV_ID, CMD_RD, 8'(i), 8'h00, reply);
			compare_byte("test_reset_read", $sformatf("read of reg %0d", i), 8'h00, reply);
		end
	endtask

	task automatic test_write_read();
		logic [7:0] val;
		for (int i = 0; i < `UC_REG_NUM; i++) begin
			val = 8'($random(seed));
			write_reg("test_write_read", 8'(i), val);
		end
		for (int i = 0; i < `UC_REG_NUM; i++)
			read_reg("test_write_read", 8'(i));
	endtask

	task automatic test_foreign_device();
		command_silent("test_foreign_device", `UC_DEV_ID ^ 8'hFF, CMD_WR, 8'd3, ~model[3]);
		read_reg("test_foreign_device", 8'd3);
	endtask

	task automatic test_bad_opcode();
		command_silent("test_bad_opcode", `UC_DEV_ID, 8'h03, 8'd6, ~model[6]);
		read_reg("test_bad_opcode", 8'd6);
		// first address past the bank aliases reg 0 in its low bits
		command_silent("test_bad_opcode", `UC_DEV_ID, CMD_WR, 8'(`UC_REG_NUM), ~model[0]);
		read_reg("test_bad_opcode", 8'd0);
	endtask

	task automatic test_frame_timeout();
		// device and mode byte of a write before the line goes idle
		align_drive();
		send_byte(`UC_DEV_ID);
		send_byte(CMD_WR);
		wait_cycles(`UC_TIMEOUT_CYCLES + 100);
		read_reg("test_frame_timeout", 8'd9);
	endtask

	initial begin
		seed = 32'h7433550f;
		rst_n = 1'b0;
		rxd = 1'b1;
		for (int i = 0; i < `UC_REG_NUM; i++)
			model[i] = 8'h00;
		repeat (8) @(posedge clk_sys);
		#DRV_DLY;
		rst_n = 1'b1;
		wait_cycles(4);
		test_reset_read();
		test_write_read();
		test_foreign_device();
		test_bad_opcode();
		test_frame_timeout();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* uart_cmd.f */
+incdir+verilog
verilog/uart_cmd_pkg.sv
verilog/uart_rx.sv
verilog/cmd_frame_dec.sv
verilog/reg_bank.sv
verilog/uart_tx.sv
verilog/uart_cmd_top.sv
testbench/tb_uart_cmd_top.sv

/* Bender.yml */
package:
  name: uart_cmd

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/uart_cmd_pkg.sv
      - verilog/uart_rx.sv
      - verilog/cmd_frame_dec.sv
      - verilog/reg_bank.sv
      - verilog/uart_tx.sv
      - verilog/uart_cmd_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/tb_uart_cmd_top.sv
